// ==== program.hex ====
// one 12-bit instruction per line: opcode nibble, then the 8-bit operand
100
200
005
201
300

// ==== tama.f ====
design/tama_pkg.sv
design/clock_enables.sv
design/program_rom.sv
design/mcu_core.sv
design/lcd_ram.sv
design/lcd_scan.sv
design/tama_top.sv
test/tama_properties.sv
test/tama_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the testbench with Verilator, the log decides pass or fail

rm -f sim.log

verilator --binary --timing --assert --top-module tama_tb -f tama.f \
  && ./obj_dir/Vtama_tb > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation stopped with an error"; exit 1; }

cat sim.log
grep -q "Testbench failed" sim.log && exit 1 || exit 0

// ==== test/tama_tb.sv ====
module tama_tb import tama_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int settle_clocks = 3000;
  localparam int tick_timeout  = 200;
  localparam int frame_timeout = 2000;

  typedef struct packed {
    logic    left;
    logic    middle;
    logic    right;
    nibble_t cell0;
  } button_row_t;

  logic clk;
  logic rst;
  logic left_button;
  logic middle_button;
  logic right_button;
  logic tick_2x;
  logic hsync;
  logic vsync;
  logic de;
  rgb_t rgb;

  int   errors;
  int   checks;
  rgb_t line_pixels [64];

  // pins are active low, cell 0 holds {0, ~left, ~middle, ~right}
  button_row_t button_table [8] = '{
    '{1'b1, 1'b1, 1'b1, 4'h0},
    '{1'b0, 1'b1, 1'b1, 4'h4},
    '{1'b1, 1'b0, 1'b1, 4'h2},
    '{1'b1, 1'b1, 1'b0, 4'h1},
    '{1'b0, 1'b0, 1'b1, 4'h6},
    '{1'b0, 1'b1, 1'b0, 4'h5},
    '{1'b1, 1'b0, 1'b0, 4'h3},
    '{1'b0, 1'b0, 1'b0, 4'h7}
  };

  tama_top UUT (
    .clk           (clk),
    .rst           (rst),
    .left_button   (left_button),
    .middle_button (middle_button),
    .right_button  (right_button),
    .tick_2x       (tick_2x),
    .hsync         (hsync),
    .vsync         (vsync),
    .de            (de),
    .rgb           (rgb)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ----------------------------------------
  // waits
  // ----------------------------------------

  task automatic wait_tick(output int clocks);
    clocks = 0;
    do begin
      @(negedge clk);
      clocks++;
    end while (!tick_2x && clocks < tick_timeout);
    if (!tick_2x) begin
      $display("timeout: no tick_2x pulse within %0d clocks", tick_timeout);
      errors++;
    end
  endtask

  // returns on the first sample where vsync is high
  task automatic find_vsync_rise();
    int   waited;
    logic prev_vsync;
    logic found;
    waited     = 0;
    prev_vsync = 1'b1;
    found      = 1'b0;
    while (!found && waited < frame_timeout) begin
      @(negedge clk);
      waited++;
      found      = vsync && !prev_vsync;
      prev_vsync = vsync;
    end
    if (!found) begin
      $display("timeout: no vsync rising edge within %0d clocks", frame_timeout);
      errors++;
    end
  endtask

  // ----------------------------------------
  // timing checks
  // ----------------------------------------

  // the half tap fires first after reset, so gaps run 50, 51, 50, ...
  task automatic measure_tick_gaps();
    int gap;
    int expected;
    wait_tick(gap);
    for (int i = 0; i < 12; i++) begin
      wait_tick(gap);
      expected = (i % 2 == 0) ? 50 : 51;
      checks++;
      if (gap != expected) begin
        $display("ERROR tick_2x gap %0d: expected 0x%0h, got 0x%0h", i, expected, gap);
        errors++;
      end
    end
  endtask

  task automatic frame_timing();
    int   de_count;
    int   vsync_count;
    int   hsync_width;
    int   hsync_rises;
    int   last_rise;
    logic prev_hsync;
    find_vsync_rise();
    de_count    = 0;
    vsync_count = 0;
    hsync_width = 0;
    hsync_rises = 0;
    last_rise   = -1;
    prev_hsync  = hsync;
    for (int t = 0; t < 1440; t++) begin
      if (de) de_count++;
      if (vsync) vsync_count++;
      if (hsync) begin
        if (!prev_hsync) begin
          hsync_rises++;
          if (last_rise >= 0) begin
            checks++;
            if (t - last_rise != 40) begin
              $display("ERROR hsync period: expected 0x%0h, got 0x%0h", 40, t - last_rise);
              errors++;
            end
          end
          last_rise = t;
        end
        hsync_width++;
      end else if (prev_hsync) begin
        checks++;
        if (hsync_width != 4) begin
          $display("ERROR hsync width: expected 0x%0h, got 0x%0h", 4, hsync_width);
          errors++;
        end
        hsync_width = 0;
      end
      prev_hsync = hsync;
      @(negedge clk);
    end
    // one hsync pulse per line, 36 lines per frame
    checks += 3;
    if (hsync_rises != 36) begin
      $display("ERROR hsync pulses: expected 0x%0h, got 0x%0h", 36, hsync_rises);
      errors++;
    end
    if (de_count != 1024) begin
      $display("ERROR de count: expected 0x%0h, got 0x%0h", 1024, de_count);
      errors++;
    end
    if (vsync_count != 80) begin
      $display("ERROR vsync width: expected 0x%0h, got 0x%0h", 80, vsync_count);
      errors++;
    end
  endtask

  // ----------------------------------------
  // pixel checks
  // ----------------------------------------

  task automatic apply_buttons(input button_row_t row);
    @(posedge clk);
    left_button   <= row.left;
    middle_button <= row.middle;
    right_button  <= row.right;
  endtask

  // the first two active lines of the next frame
  task automatic capture_pixels();
    int count;
    int waited;
    for (int i = 0; i < 64; i++) begin
      line_pixels[i] = color_black;
    end
    find_vsync_rise();
    count  = 0;
    waited = 0;
    while (count < 64 && waited < frame_timeout) begin
      @(negedge clk);
      waited++;
      if (de) begin
        line_pixels[count] = rgb;
        count++;
      end
    end
    if (count < 64) begin
      $display("timeout: only %0d active pixels seen after vsync", count);
      errors++;
    end
  endtask

  task automatic compare_pixels(input int row, input nibble_t cell0);
    logic [31:0] line_bits;
    rgb_t        expected;
    // cell 1 always holds 5, everything to the right stays cleared
    line_bits = {cell0, 4'h5, 24'h000000};
    for (int i = 0; i < 64; i++) begin
      // after 32 shifts the pattern is all zero, as the second line should be
      expected  = line_bits[31] ? color_on : color_off;
      line_bits = line_bits << 1;
      checks++;
      if (line_pixels[i] !== expected) begin
        $display("ERROR rgb row %0d pixel %0d: expected 0x%06h, got 0x%06h",
                 row, i, expected, line_pixels[i]);
        errors++;
      end
    end
  endtask

  initial begin
    errors        = 0;
    checks        = 0;
    rst           = 1'b1;
    left_button   = 1'b1;
    middle_button = 1'b1;
    right_button  = 1'b1;
    repeat (3) @(posedge clk);
    rst <= 1'b0;

    measure_tick_gaps();
    frame_timing();

    for (int r = 0; r < 8; r++) begin
      apply_buttons(button_table[r]);
      repeat (settle_clocks) @(posedge clk);
      capture_pixels();
      compare_pixels(r, button_table[r].cell0);
    end

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// ==== test/tama_properties.sv ====
module tama_properties import tama_pkg::*; (
  input logic clk,
  input logic rst,
  input logic en_base,
  input logic en_2x,
  input logic hsync,
  input logic vsync,
  input logic de,
  input rgb_t rgb
);

  timeunit 1ns;
  timeprecision 1ps;

  // ----------------------------------------
  // clock enables
  // ----------------------------------------

  base_with_2x: assert property (@(posedge clk) disable iff (rst) en_base |-> en_2x)
    else $error("en_base pulsed without en_2x");

  base_single_cycle: assert property (@(posedge clk) disable iff (rst) en_base |=> !en_base)
    else $error("en_base high on two consecutive cycles");

  // ----------------------------------------
  // video outputs
  // ----------------------------------------

  // sync pulses sit in the blanking interval only
  sync_in_blanking: assert property (@(posedge clk) disable iff (rst) de |-> (!hsync && !vsync))
    else $error("hsync or vsync high while de is high");

  black_in_blanking: assert property (@(posedge clk) disable iff (rst)
    !de |-> (rgb == color_black))
    else $error("rgb not black while de is low");

endmodule

bind tama_top tama_properties props (
  .clk     (clk),
  .rst     (rst),
  .en_base (en_base),
  .en_2x   (tick_2x),
  .hsync   (hsync),
  .vsync   (vsync),
  .de      (de),
  .rgb     (rgb)
);

// ==== design/tama_top.sv ====
module tama_top import tama_pkg::*; (
  input  logic clk,
  input  logic rst,

  input  logic left_button,
  input  logic middle_button,
  input  logic right_button,

  output logic tick_2x,

  output logic hsync,
  output logic vsync,
  output logic de,
  output rgb_t rgb
);

  logic      en_base;

  pc_t       rom_addr;
  instr_t    rom_data;

  logic      lcd_we;
  lcd_addr_t lcd_waddr;
  nibble_t   lcd_wdata;
  lcd_addr_t lcd_raddr;
  nibble_t   lcd_rdata;

  // the double-rate enable is also the tick brought out of the chip
  clock_enables enables (
    .clk     (clk),
    .rst     (rst),
    .en_base (en_base),
    .en_2x   (tick_2x)
  );

  program_rom rom (
    .clk      (clk),
    .rom_addr (rom_addr),
    .rom_data (rom_data)
  );

  mcu_core core (
    .clk           (clk),
    .rst           (rst),
    .en_base       (en_base),
    .en_2x         (tick_2x),
    .left_button   (left_button),
    .middle_button (middle_button),
    .right_button  (right_button),
    .rom_addr      (rom_addr),
    .rom_data      (rom_data),
    .lcd_we        (lcd_we),
    .lcd_waddr     (lcd_waddr),
    .lcd_wdata     (lcd_wdata)
  );

  lcd_ram segments (
    .clk       (clk),
    .lcd_we    (lcd_we),
    .lcd_waddr (lcd_waddr),
    .lcd_wdata (lcd_wdata),
    .lcd_raddr (lcd_raddr),
    .lcd_rdata (lcd_rdata)
  );

  lcd_scan scan (
    .clk       (clk),
    .rst       (rst),
    .lcd_raddr (lcd_raddr),
    .lcd_rdata (lcd_rdata),
    .hsync     (hsync),
    .vsync     (vsync),
    .de        (de),
    .rgb       (rgb)
  );

endmodule

// ==== design/lcd_scan.sv ====
module lcd_scan import tama_pkg::*; (
  input  logic      clk,
  input  logic      rst,

  output lcd_addr_t lcd_raddr,
  input  nibble_t   lcd_rdata,

  output logic      hsync,
  output logic      vsync,
  output logic      de,
  output rgb_t      rgb
);

  scan_pos_t  h;
  scan_pos_t  v;

  logic [1:0] s1_bit;
  logic       s1_active;
  logic       s1_hsync;
  logic       s1_vsync;

  logic       pixel_on;

  // ----------------------------------------
  // raster counters
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      h <= '0;
      v <= '0;
    end else if (h == h_total - 6'd1) begin
      h <= '0;
      if (v == v_total - 6'd1) begin
        v <= '0;
      end else begin
        v <= v + 6'd1;
      end
    end else begin
      h <= h + 6'd1;
    end
  end

  // eight cells per row, each cell covering four pixels
  assign lcd_raddr = {v[4:0], h[4:2]};

  // ----------------------------------------
  // stage 1, waiting for the memory read
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_bit    <= '0;
      s1_active <= 1'b0;
      s1_hsync  <= 1'b0;
      s1_vsync  <= 1'b0;
    end else begin
      s1_bit    <= h[1:0];
      s1_active <= (h < h_active) && (v < v_active);
      s1_hsync  <= (h >= hsync_start) && (h <= hsync_end);
      s1_vsync  <= (v >= vsync_start) && (v <= vsync_end);
    end
  end

  // ----------------------------------------
  // stage 2, pixel colour
  // ----------------------------------------

  // bit 3 is the leftmost pixel of a cell
  assign pixel_on = lcd_rdata[2'd3 - s1_bit];

  always_ff @(posedge clk) begin
    if (rst) begin
      hsync <= 1'b0;
      vsync <= 1'b0;
      de    <= 1'b0;
      rgb   <= color_black;
    end else begin
      hsync <= s1_hsync;
      vsync <= s1_vsync;
      de    <= s1_active;
      if (!s1_active) begin
        rgb <= color_black;
      end else if (pixel_on) begin
        rgb <= color_on;
      end else begin
        rgb <= color_off;
      end
    end
  end

endmodule

// ==== design/lcd_ram.sv ====
module lcd_ram import tama_pkg::*; (
  input  logic      clk,

  input  logic      lcd_we,
  input  lcd_addr_t lcd_waddr,
  input  nibble_t   lcd_wdata,

  input  lcd_addr_t lcd_raddr,
  output nibble_t   lcd_rdata
);

  nibble_t mem [256];

  // all segments start cleared at power-up
  initial begin
    for (int i = 0; i < 256; i++) begin
      mem[i] = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (lcd_we) begin
      mem[lcd_waddr] <= lcd_wdata;
    end
  end

  always_ff @(posedge clk) begin
    lcd_rdata <= mem[lcd_raddr];
  end

endmodule

// ==== design/mcu_core.sv ====
module mcu_core import tama_pkg::*; (
  input  logic      clk,
  input  logic      rst,

  input  logic      en_base,
  input  logic      en_2x,

  input  logic      left_button,
  input  logic      middle_button,
  input  logic      right_button,

  output pc_t       rom_addr,
  input  instr_t    rom_data,

  output logic      lcd_we,
  output lcd_addr_t lcd_waddr,
  output nibble_t   lcd_wdata
);

  pc_t        pc;
  nibble_t    acc;
  instr_t     instr;
  logic       fetch_pending;

  nibble_t    button_port;
  opcode_t    opcode;
  logic [7:0] operand;
  nibble_t    imm;

  // the pins idle high, so a pressed button reads as a 1 here
  assign button_port = {1'b0, ~left_button, ~middle_button, ~right_button};

  // ----------------------------------------
  // fetch
  // ----------------------------------------

  // the rom sees pc all the time, the half tick decides when the word is taken
  assign rom_addr = pc;

  always_ff @(posedge clk) begin
    if (rst) begin
      fetch_pending <= 1'b0;
    end else begin
      fetch_pending <= en_2x & ~en_base;
    end
  end

  // rom data arrives one clock after the half tick
  always_ff @(posedge clk) begin
    if (fetch_pending) begin
      instr <= rom_data;
    end
  end

  // ----------------------------------------
  // decode and execute
  // ----------------------------------------

  assign opcode  = opcode_t'(instr[11:8]);
  assign operand = instr[7:0];
  assign imm     = operand[3:0];

  always_ff @(posedge clk) begin
    if (rst) begin
      pc  <= '0;
      acc <= '0;
    end else if (en_base) begin
      pc <= pc + 8'd1;

      case (opcode)
        op_ldi: begin
          acc <= imm;
        end
        op_in: begin
          acc <= button_port;
        end
        op_jmp: begin
          pc <= operand;
        end
        op_addi: begin
          acc <= acc + imm;
        end
        // op_st only drives the lcd write port below
        default: begin
        end
      endcase
    end
  end

  // the store is issued on the base tick itself and lands in the memory on that edge
  assign lcd_we    = en_base && (opcode == op_st);
  assign lcd_waddr = operand;
  assign lcd_wdata = acc;

endmodule

// ==== design/program_rom.sv ====
module program_rom import tama_pkg::*; (
  input  logic   clk,
  input  pc_t    rom_addr,
  output instr_t rom_data
);

  instr_t mem [256];

  initial begin
    $readmemh("program.hex", mem);
  end

  // one word per clock, valid the cycle after the address
  always_ff @(posedge clk) begin
    rom_data <= mem[rom_addr];
  end

endmodule

// ==== design/clock_enables.sv ====
module clock_enables import tama_pkg::*; (
  input  logic clk,
  input  logic rst,
  output logic en_base,
  output logic en_2x
);

  div_cnt_t cnt;

  // the counter runs down from div_reload, so one base period is div_reload + 1 clocks
  // and the half tap splits it into 50 and 51
  always_ff @(posedge clk) begin
    if (rst) begin
      cnt     <= div_reload;
      en_base <= 1'b0;
      en_2x   <= 1'b0;
    end else begin
      en_base <= 1'b0;
      en_2x   <= 1'b0;
      cnt     <= cnt - 10'd1;

      if (cnt == '0) begin
        cnt     <= div_reload;
        en_base <= 1'b1;
        en_2x   <= 1'b1;
      end else if (cnt == div_half) begin
        en_2x <= 1'b1;
      end
    end
  end

endmodule

// ==== design/tama_pkg.sv ====
package tama_pkg;

  // ----------------------------------------
  // data widths
  // ----------------------------------------

  typedef logic [3:0]  nibble_t;
  typedef logic [11:0] instr_t;
  typedef logic [7:0]  pc_t;
  typedef logic [7:0]  lcd_addr_t;
  typedef logic [23:0] rgb_t;
  typedef logic [9:0]  div_cnt_t;
  typedef logic [5:0]  scan_pos_t;

  // top nibble of an instruction word, anything not listed runs as a no-op
  typedef enum logic [3:0] {
    op_ldi  = 4'd0,
    op_in   = 4'd1,
    op_st   = 4'd2,
    op_jmp  = 4'd3,
    op_addi = 4'd4
  } opcode_t;

  // ----------------------------------------
  // clock enable divider
  // ----------------------------------------

  localparam div_cnt_t div_reload = 10'd100;
  localparam div_cnt_t div_half   = 10'd50;

  // ----------------------------------------
  // video timing and colours
  // ----------------------------------------

  localparam scan_pos_t h_total     = 6'd40;
  localparam scan_pos_t h_active    = 6'd32;
  localparam scan_pos_t hsync_start = 6'd34;
  localparam scan_pos_t hsync_end   = 6'd37;

  localparam scan_pos_t v_total     = 6'd36;
  localparam scan_pos_t v_active    = 6'd32;
  localparam scan_pos_t vsync_start = 6'd33;
  localparam scan_pos_t vsync_end   = 6'd34;

  localparam rgb_t color_on    = 24'h202020;
  localparam rgb_t color_off   = 24'hb0c0a0;
  localparam rgb_t color_black = 24'h000000;

endpackage
